// File: mod_arith_pkg.sv
// Arithmetic types shared by the remainder unit and the sequencers that feed it

package mod_arith_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Width of data, modulus and remainder
  localparam int DATA_WIDTH = 32;

  // Bit counter for the shift loop
  localparam int REM_CNT_WIDTH = $clog2(DATA_WIDTH);

  ////////////////////
  // Operand
  ////////////////////

  // One matrix element with its own modulus
  // Modulus sits in the upper half
  typedef struct packed {
    logic [DATA_WIDTH-1:0] modulus;
    logic [DATA_WIDTH-1:0] data;
  } mod_operand_t;

  ////////////////////
  // Remainder FSM
  ////////////////////

  // Idle until start
  // Shift one dividend bit per cycle
  // Done holds for a single cycle
  typedef enum logic [1:0] {
    REM_IDLE,
    REM_SHIFT,
    REM_DONE
  } rem_state_t;

endpackage : mod_arith_pkg

// File: matrix_stream_pkg.sv
// Matrix shape and sequencer state types for the row and element walkers

package matrix_stream_pkg;

  ////////////////////
  // Dimensions
  ////////////////////

  // Row or column count width
  localparam int DIM_WIDTH = 8;

  // Matrix shape latched on start
  typedef struct packed {
    logic [DIM_WIDTH-1:0] rows;
    logic [DIM_WIDTH-1:0] cols;
  } matrix_dims_t;

  ////////////////////
  // Sequencer FSMs
  ////////////////////

  // Matrix level
  // Row state waits for an element strobe from the host
  typedef enum logic [1:0] {
    MAT_IDLE,
    MAT_ROW,
    MAT_WAIT
  } mat_state_t;

  // Vector level
  // Feed state waits for the next element of the row
  typedef enum logic [1:0] {
    VEC_IDLE,
    VEC_FEED,
    VEC_WAIT
  } vec_state_t;

endpackage : matrix_stream_pkg

// File: scalar_mod.sv
// Iterative unsigned remainder of one element, restoring shift-subtract one bit per cycle
`timescale 1ns/100ps

module scalar_mod (
  input  logic                                CLK,
  input  logic                                RST,

  // Control
  input  logic                                start,
  output logic                                done,

  // Data
  input  mod_arith_pkg::mod_operand_t         operand,
  output logic [mod_arith_pkg::DATA_WIDTH-1:0] remainder
);

  import mod_arith_pkg::*;

  ////////////////////
  // Signals
  ////////////////////

  // FSM
  rem_state_t               state_q;
  logic [REM_CNT_WIDTH-1:0] bit_cnt_q;

  // Latched divisor
  logic [DATA_WIDTH-1:0]    modulus_q;
  // Dividend bits still to shift in, MSB first
  logic [DATA_WIDTH-1:0]    dividend_q;
  // Running remainder
  logic [DATA_WIDTH-1:0]    partial_q;

  // One extra bit for the shifted trial value
  logic [DATA_WIDTH:0]      trial;
  logic [DATA_WIDTH:0]      diff;
  logic                     take;
  logic [DATA_WIDTH-1:0]    partial_next;

  ////////////////////
  // Datapath
  ////////////////////

  // Bring down next dividend bit
  assign trial = {partial_q, dividend_q[DATA_WIDTH-1]};
  assign diff  = trial - {1'b0, modulus_q};

  // Subtract only when it fits
  // Zero modulus always fits and subtracts nothing
  assign take = (trial >= {1'b0, modulus_q});

  // Either branch stays below the modulus, so the top bit is zero
  assign partial_next = take ? diff[DATA_WIDTH-1:0] : trial[DATA_WIDTH-1:0];

  assign remainder = partial_q;
  assign done      = (state_q == REM_DONE);

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q   <= REM_IDLE;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        REM_IDLE: begin
          if (start) begin
            // One cycle per dividend bit
            bit_cnt_q <= REM_CNT_WIDTH'(DATA_WIDTH - 1);
            state_q   <= REM_SHIFT;
          end
        end
        REM_SHIFT: begin
          // Last bit handled this cycle
          if (bit_cnt_q == '0) begin
            state_q <= REM_DONE;
          end else begin
            bit_cnt_q <= bit_cnt_q - 1'b1;
          end
        end
        REM_DONE: begin
          state_q <= REM_IDLE;
        end
        default: begin
          state_q <= REM_IDLE;
        end
      endcase
    end
  end

  // Operand latch and shift registers
  always_ff @(posedge CLK) begin
    if (state_q == REM_IDLE && start) begin
      modulus_q  <= operand.modulus;
      dividend_q <= operand.data;
      partial_q  <= '0;
    end else if (state_q == REM_SHIFT) begin
      partial_q  <= partial_next;
      dividend_q <= dividend_q << 1;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Result strobe is a single pulse
  assert property (@(posedge CLK) disable iff (RST) done |=> !done);

  // Caller must wait for the previous result
  assert property (@(posedge CLK) disable iff (RST) start |-> state_q == REM_IDLE);

endmodule : scalar_mod

// File: vector_mod.sv
// Row walker that sends each element of one row through the remainder unit and flags the row end
`timescale 1ns/100ps

module vector_mod (
  input  logic                                    CLK,
  input  logic                                    RST,

  // Control
  input  logic                                    start,
  input  logic                                    in_enable,
  output logic                                    out_enable,
  output logic                                    ready,

  // Data
  input  logic [matrix_stream_pkg::DIM_WIDTH-1:0] size,
  input  mod_arith_pkg::mod_operand_t             operand,
  output logic [mod_arith_pkg::DATA_WIDTH-1:0]    data_out
);

  import mod_arith_pkg::*;
  import matrix_stream_pkg::*;

  ////////////////////
  // Signals
  ////////////////////

  // FSM
  vec_state_t            state_q;

  // Row length and element position
  logic [DIM_WIDTH-1:0]  size_q;
  logic [DIM_WIDTH-1:0]  elem_idx_q;
  logic                  last_elem;

  // Remainder unit
  logic                  accept;
  logic                  rem_done;
  logic [DATA_WIDTH-1:0] rem_value;

  ////////////////////
  // Body
  ////////////////////

  // First element arrives with start
  // Later ones only while feeding
  assign accept = in_enable && (start || state_q == VEC_FEED);

  assign last_elem = (elem_idx_q == size_q - DIM_WIDTH'(1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q    <= VEC_IDLE;
      size_q     <= '0;
      elem_idx_q <= '0;
      out_enable <= 1'b0;
      ready      <= 1'b0;
    end else begin
      // Strobes default low
      out_enable <= 1'b0;
      ready      <= 1'b0;

      // New row
      if (start) begin
        size_q     <= size;
        elem_idx_q <= '0;
      end

      case (state_q)
        VEC_IDLE: begin
          if (accept) begin
            state_q <= VEC_WAIT;
          end else if (start) begin
            state_q <= VEC_FEED;
          end
        end
        VEC_FEED: begin
          if (accept) begin
            state_q <= VEC_WAIT;
          end
        end
        VEC_WAIT: begin
          if (rem_done) begin
            out_enable <= 1'b1;
            if (last_elem) begin
              // Row end rides on the last result
              ready   <= 1'b1;
              state_q <= VEC_IDLE;
            end else begin
              elem_idx_q <= elem_idx_q + 1'b1;
              state_q    <= VEC_FEED;
            end
          end
        end
        default: begin
          state_q <= VEC_IDLE;
        end
      endcase
    end
  end

  // Result register
  always_ff @(posedge CLK) begin
    if (state_q == VEC_WAIT && rem_done) begin
      data_out <= rem_value;
    end
  end

  scalar_mod u_scalar_mod (
    .CLK      (CLK),
    .RST      (RST),
    .start    (accept),
    .done     (rem_done),
    .operand  (operand),
    .remainder(rem_value)
  );

  // Row end only with a result, and the walker is then idle
  assert property (@(posedge CLK) disable iff (RST)
    ready |-> out_enable && state_q == VEC_IDLE);

endmodule : vector_mod

// File: matrix_mod.sv
// Top level matrix remainder engine, counts rows and streams elements to the row walker
`timescale 1ns/100ps

module matrix_mod (
  input  logic                                 CLK,
  input  logic                                 RST,

  // Control
  input  logic                                 start,
  output logic                                 ready,

  input  logic                                 in_i_enable,
  input  logic                                 in_j_enable,
  output logic                                 out_i_enable,
  output logic                                 out_j_enable,

  // Data
  input  matrix_stream_pkg::matrix_dims_t      dims,
  input  mod_arith_pkg::mod_operand_t          operand,
  output logic [mod_arith_pkg::DATA_WIDTH-1:0] data_out
);

  import mod_arith_pkg::*;
  import matrix_stream_pkg::*;

  ////////////////////
  // Signals
  ////////////////////

  // FSM
  mat_state_t            state_q;

  // Shape and row position
  matrix_dims_t          dims_q;
  logic [DIM_WIDTH-1:0]  row_idx_q;
  logic                  last_row;
  logic                  elem_strobe;

  // Row walker
  logic                  vec_start;
  logic                  vec_in_enable;
  mod_operand_t          operand_q;
  logic                  vec_out_enable;
  logic                  vec_ready;
  logic [DATA_WIDTH-1:0] vec_data_out;

  ////////////////////
  // Body
  ////////////////////

  assign last_row = (row_idx_q == dims_q.rows - DIM_WIDTH'(1));

  // Host element strobe while waiting for one
  assign elem_strobe = (state_q == MAT_ROW) && (in_i_enable || in_j_enable);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q       <= MAT_IDLE;
      dims_q        <= '0;
      row_idx_q     <= '0;
      vec_start     <= 1'b0;
      vec_in_enable <= 1'b0;
      out_i_enable  <= 1'b0;
      out_j_enable  <= 1'b0;
      ready         <= 1'b0;
    end else begin
      // Pulses default low
      vec_start     <= 1'b0;
      vec_in_enable <= 1'b0;
      out_i_enable  <= 1'b0;
      out_j_enable  <= 1'b0;
      ready         <= 1'b0;

      case (state_q)
        MAT_IDLE: begin
          if (start) begin
            dims_q    <= dims;
            row_idx_q <= '0;
            state_q   <= MAT_ROW;
          end
        end
        MAT_ROW: begin
          // First element of a row restarts the walker
          if (in_i_enable) begin
            vec_start     <= 1'b1;
            vec_in_enable <= 1'b1;
            state_q       <= MAT_WAIT;
          end else if (in_j_enable) begin
            vec_in_enable <= 1'b1;
            state_q       <= MAT_WAIT;
          end
        end
        MAT_WAIT: begin
          if (vec_out_enable) begin
            out_j_enable <= 1'b1;
            if (vec_ready && last_row) begin
              // Matrix finished
              ready   <= 1'b1;
              state_q <= MAT_IDLE;
            end else if (vec_ready) begin
              row_idx_q    <= row_idx_q + 1'b1;
              out_i_enable <= 1'b1;
              state_q      <= MAT_ROW;
            end else begin
              state_q <= MAT_ROW;
            end
          end
        end
        default: begin
          state_q <= MAT_IDLE;
        end
      endcase
    end
  end

  // Operand and result registers
  always_ff @(posedge CLK) begin
    if (elem_strobe) begin
      operand_q <= operand;
    end
    if (state_q == MAT_WAIT && vec_out_enable) begin
      data_out <= vec_data_out;
    end
  end

  vector_mod u_vector_mod (
    .CLK       (CLK),
    .RST       (RST),
    .start     (vec_start),
    .in_enable (vec_in_enable),
    .out_enable(vec_out_enable),
    .ready     (vec_ready),
    .size      (dims_q.cols),
    .operand   (operand_q),
    .data_out  (vec_data_out)
  );

  ////////////////////
  // Checks
  ////////////////////

  // Fixed latency through the row walker and remainder unit
  assert property (@(posedge CLK) disable iff (RST)
    vec_in_enable |-> ##(DATA_WIDTH + 2) vec_out_enable);

  // Row walker answers only while an element is in flight
  assert property (@(posedge CLK) disable iff (RST)
    vec_out_enable |-> state_q == MAT_WAIT);

endmodule : matrix_mod

// File: tb_matrix_mod.sv
// Self-checking testbench for the matrix remainder engine, compiled as the simulation top
`timescale 1ns/100ps

module tb_matrix_mod;

  import mod_arith_pkg::*;
  import matrix_stream_pkg::*;

  ////////////////////
  // Setup
  ////////////////////

  // Cycles allowed for one result
  localparam int RESULT_TIMEOUT = 200;
  localparam int RESET_CYCLES   = 16;

  logic                  CLK;
  logic                  RST;
  logic                  start;
  matrix_dims_t          dims;
  logic                  in_i_enable;
  logic                  in_j_enable;
  mod_operand_t          operand;
  logic [DATA_WIDTH-1:0] data_out;
  logic                  out_i_enable;
  logic                  out_j_enable;
  logic                  ready;

  // Error tallies by kind
  int err_data;
  int err_row;
  int err_end;
  int err_other;
  int num_checks;
  int tests_run;
  int tests_failed;
  bit timed_out;

  // Pulses seen over one matrix
  int row_pulses;
  int end_pulses;
  int res_pulses;
  // Edge modulus kind, rotates per element
  int edge_kind;
  logic [DATA_WIDTH-1:0] last_data_out;

  matrix_mod UUT (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .ready       (ready),
    .in_i_enable (in_i_enable),
    .in_j_enable (in_j_enable),
    .out_i_enable(out_i_enable),
    .out_j_enable(out_j_enable),
    .dims        (dims),
    .operand     (operand),
    .data_out    (data_out)
  );

  always #5 CLK = ~CLK;

  ////////////////////
  // Monitor
  ////////////////////

  // Mid-cycle view of the output strobes
  always @(negedge CLK) begin
    if (!RST) begin
      if (out_j_enable) begin
        res_pulses++;
      end
      if (out_i_enable) begin
        row_pulses++;
      end
      if (ready) begin
        end_pulses++;
      end
      if (ready && !out_j_enable) begin
        $display("ERROR ready pulsed without a result on out_j_enable");
        err_end++;
      end
      if (out_i_enable && !out_j_enable) begin
        $display("ERROR out_i_enable pulsed without a result on out_j_enable");
        err_row++;
      end
      // Result register moves only with its strobe
      if (data_out !== last_data_out && !out_j_enable) begin
        $display("ERROR data_out: changed to %h from %h without out_j_enable",
                 data_out, last_data_out);
        err_data++;
      end
    end
    last_data_out = data_out;
  end

  ////////////////////
  // Model
  ////////////////////

  // Unsigned remainder, zero modulus passes data through
  function automatic logic [DATA_WIDTH-1:0] expected_rem(input mod_operand_t op);
    if (op.modulus == '0) begin
      return op.data;
    end
    return op.data % op.modulus;
  endfunction

  function automatic mod_operand_t random_operand();
    mod_operand_t op;
    op.data = $urandom;
    // Mix of modulus sizes
    case ($urandom % 4)
      0: op.modulus = $urandom;
      1: op.modulus = $urandom & 32'h0000_ffff;
      2: op.modulus = $urandom & 32'h0000_00ff;
      default: op.modulus = $urandom % 5;
    endcase
    return op;
  endfunction

  // Zero, one, above data, equal to data
  function automatic mod_operand_t edge_operand(input int kind);
    mod_operand_t op;
    op.data = $urandom;
    case (kind % 4)
      0: op.modulus = '0;
      1: op.modulus = 32'd1;
      2: begin
        // Headroom so the sum cannot wrap
        op.data    = op.data >> 1;
        op.modulus = op.data + 32'd1 + ($urandom & 32'h0000_0fff);
      end
      default: op.modulus = op.data;
    endcase
    return op;
  endfunction

  function automatic int total_errors();
    return err_data + err_row + err_end + err_other;
  endfunction

  ////////////////////
  // Tasks
  ////////////////////

  // Strobes low outside any matrix
  task automatic check_quiet();
    if (out_i_enable !== 1'b0) begin
      $display("ERROR out_i_enable: got %h expected %h", out_i_enable, 1'b0);
      err_other++;
    end
    if (out_j_enable !== 1'b0) begin
      $display("ERROR out_j_enable: got %h expected %h", out_j_enable, 1'b0);
      err_other++;
    end
    if (ready !== 1'b0) begin
      $display("ERROR ready: got %h expected %h", ready, 1'b0);
      err_other++;
    end
    num_checks += 3;
  endtask

  // Returns at the negedge where out_j_enable is high
  task automatic wait_result();
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (out_j_enable !== 1'b1 && cycles < RESULT_TIMEOUT) begin
      cycles++;
      @(negedge CLK);
    end
    if (out_j_enable !== 1'b1) begin
      $display("Timeout: no result on out_j_enable within %0d cycles", RESULT_TIMEOUT);
      timed_out = 1'b1;
      err_other++;
    end
  endtask

  // One whole matrix, element by element in row order
  task automatic run_matrix(input int rows, input int cols, input bit use_edge);
    matrix_dims_t          d;
    mod_operand_t          op;
    logic [DATA_WIDTH-1:0] exp_data;
    logic                  exp_row;
    logic                  exp_end;
    if (timed_out) begin
      return;
    end
    row_pulses = 0;
    end_pulses = 0;
    res_pulses = 0;
    d.rows = DIM_WIDTH'(rows);
    d.cols = DIM_WIDTH'(cols);
    @(posedge CLK);
    dims  <= d;
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        if (use_edge) begin
          op = edge_operand(edge_kind);
          edge_kind++;
        end else begin
          op = random_operand();
        end
        exp_data = expected_rem(op);
        // Row end on every last column, matrix end on the very last one
        exp_row = (c == cols - 1) && (r != rows - 1);
        exp_end = (c == cols - 1) && (r == rows - 1);
        @(posedge CLK);
        operand <= op;
        if (c == 0) begin
          in_i_enable <= 1'b1;
        end else begin
          in_j_enable <= 1'b1;
        end
        @(posedge CLK);
        in_i_enable <= 1'b0;
        in_j_enable <= 1'b0;
        wait_result();
        if (timed_out) begin
          return;
        end
        if (data_out !== exp_data) begin
          $display("ERROR data_out: got %h expected %h (row %0d col %0d)",
                   data_out, exp_data, r, c);
          err_data++;
        end
        if (out_i_enable !== exp_row) begin
          $display("ERROR out_i_enable: got %h expected %h", out_i_enable, exp_row);
          err_row++;
        end
        if (ready !== exp_end) begin
          $display("ERROR ready: got %h expected %h", ready, exp_end);
          err_end++;
        end
        num_checks += 3;
      end
    end
    // Let the monitor settle its counts
    @(posedge CLK);
    if (row_pulses != rows - 1) begin
      $display("ERROR out_i_enable pulse count: got %h expected %h", row_pulses, rows - 1);
      err_row++;
    end
    if (end_pulses != 1) begin
      $display("ERROR ready pulse count: got %h expected %h", end_pulses, 1);
      err_end++;
    end
    // One result strobe per element, no extras
    if (res_pulses != rows * cols) begin
      $display("ERROR out_j_enable pulse count: got %h expected %h", res_pulses, rows * cols);
      err_data++;
    end
    num_checks += 3;
  endtask

  task automatic finish_test(input string name, input int errs);
    tests_run++;
    if (errs != 0 || timed_out) begin
      tests_failed++;
      $display("Test %-18s FAIL, %0d errors", name, errs);
    end else begin
      $display("Test %-18s ok", name);
    end
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    int d0;
    int r0;
    int e0;
    int t0;
    CLK          = 1'b0;
    RST          = 1'b1;
    start        = 1'b0;
    dims         = '0;
    in_i_enable  = 1'b0;
    in_j_enable  = 1'b0;
    operand      = '0;
    err_data     = 0;
    err_row      = 0;
    err_end      = 0;
    err_other    = 0;
    num_checks   = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    edge_kind    = 0;
    void'($urandom(32'hd0d9));

    // Reset held over 16 rising edges
    t0 = total_errors();
    repeat (RESET_CYCLES - 1) begin
      @(negedge CLK);
      check_quiet();
    end
    @(posedge CLK);
    RST <= 1'b0;
    repeat (4) begin
      @(negedge CLK);
      check_quiet();
    end
    finish_test("reset", total_errors() - t0);

    // Random shapes, flags checked alongside data
    d0 = err_data;
    r0 = err_row;
    e0 = err_end;
    repeat (12) begin
      run_matrix(1 + int'($urandom % 6), 1 + int'($urandom % 6), 1'b0);
    end
    finish_test("random matrices", err_data - d0);
    finish_test("row boundaries", err_row - r0);
    finish_test("matrix end", err_end - e0);

    t0 = total_errors();
    run_matrix(2, 4, 1'b1);
    run_matrix(3, 3, 1'b1);
    run_matrix(4, 2, 1'b1);
    finish_test("edge moduli", total_errors() - t0);

    // Back to back, each with its own start
    t0 = total_errors();
    run_matrix(1, 1, 1'b0);
    run_matrix(1, 6, 1'b0);
    run_matrix(6, 1, 1'b0);
    run_matrix(1, 1, 1'b1);
    run_matrix(1, 5, 1'b1);
    run_matrix(5, 1, 1'b1);
    finish_test("degenerate shapes", total_errors() - t0);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, num_checks, total_errors());
    if (timed_out || tests_failed != 0 || total_errors() != 0) begin
      $display("TESTS FAILED");
    end else begin
      $display("TESTS PASSED");
    end
    $finish;
  end

endmodule : tb_matrix_mod

// File: filelist.f
mod_arith_pkg.sv
matrix_stream_pkg.sv
scalar_mod.sv
vector_mod.sv
matrix_mod.sv
tb_matrix_mod.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the matrix remainder testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module tb_matrix_mod \
  -Mdir "$BUILD_DIR" -o tb_matrix_mod \
  -f filelist.f

"./$BUILD_DIR/tb_matrix_mod" 2>&1 | tee "$LOG_FILE"

if grep -q "TESTS FAILED" "$LOG_FILE"; then
  echo "Simulation failed, see $LOG_FILE"
  exit 1
fi
echo "Simulation passed"
